/* vlog.f */
+incdir+testbench
logic/memif_pkg.sv
logic/fetch_unit.sv
logic/data_port.sv
logic/bus_arbiter.sv
logic/mem_access_top.sv
testbench/tb_mem_access.sv

/* Makefile */
# Verilator flow for the memory access block
TB_TOP = tb_mem_access

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module mem_access_top

sim:
	verilator --binary --assert -f vlog.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP)

clean:
	rm -rf obj_dir

/* testbench/tb_checks.svh */
/*
 * Memory model and typed compare tasks for the memory access testbench.
 * Included inside the testbench module. The first mismatch ends the run.
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

memif_pkg::word_t ref_mem [memif_pkg::addr_t];    // expected contents, updated on data_done
memif_pkg::word_t bus_mem [memif_pkg::addr_t];    // responder contents, updated on mem_done

function automatic memif_pkg::word_t fill_word(memif_pkg::addr_t a);
    return a ^ 32'h5a5a_a5a5;
endfunction

function automatic memif_pkg::word_t merge_word(memif_pkg::word_t old, memif_pkg::word_t wdata,
                                                memif_pkg::strb_t strb);
    memif_pkg::word_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old & ~mask) | (wdata & mask);
endfunction

function automatic memif_pkg::word_t ref_word(memif_pkg::addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
endfunction

function automatic memif_pkg::word_t bus_word(memif_pkg::addr_t a);
    return bus_mem.exists(a) ? bus_mem[a] : fill_word(a);
endfunction

task automatic stop_run(string line);
    $display("%s", line);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
endtask

task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
    stop_run($sformatf("Fail %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_inst_pc(memif_pkg::addr_t got, memif_pkg::addr_t exp);
    if (got !== exp) report_mismatch("inst_pc", got, exp);
endtask

task automatic check_inst_word(memif_pkg::word_t got, memif_pkg::word_t exp);
    if (got !== exp) report_mismatch("inst_word", got, exp);
endtask

task automatic check_load_data(memif_pkg::word_t got, memif_pkg::word_t exp);
    if (got !== exp) report_mismatch("data_rdata", got, exp);
endtask

task automatic check_bus_addr(memif_pkg::addr_t got, memif_pkg::addr_t exp);
    if (got !== exp) report_mismatch("mem_addr", got, exp);
endtask

task automatic check_bus_word(memif_pkg::word_t got, memif_pkg::word_t exp);
    if (got !== exp) report_mismatch("mem_wdata", got, exp);
endtask

task automatic check_bus_strb(memif_pkg::strb_t got, memif_pkg::strb_t exp);
    if (got !== exp) report_mismatch("mem_wstrb", 32'(got), 32'(exp));
endtask

task automatic check_bit(string what, logic got, logic exp);
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
endtask

`endif

/* testbench/tb_mem_access.sv */
/*
 * Testbench for mem_access_top. Plays the memory with random latency, drives
 * random loads, stores and redirects, and scores fetched words and load data.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_access;

    localparam memif_pkg::addr_t RESET_PC   = 32'h0000_1000;
    localparam memif_pkg::addr_t WIN_BASE   = 32'h0000_1000;
    localparam int unsigned      WIN_WORDS  = 64;
    localparam int unsigned      N_OPS      = 200;              // loads and stores
    localparam int unsigned      MAX_CYCLES = 40 * N_OPS;

    logic             aclk = 1'b0;
    logic             rst_n;
    logic             redirect;
    memif_pkg::addr_t redirect_pc;
    logic             inst_valid;
    memif_pkg::addr_t inst_pc;
    memif_pkg::word_t inst_word;
    logic             data_req;
    logic             data_we;
    memif_pkg::addr_t data_addr;
    memif_pkg::word_t data_wdata;
    memif_pkg::strb_t data_wstrb;
    logic             data_done;
    memif_pkg::word_t data_rdata;
    logic             data_busy;
    logic             mem_req;
    logic             mem_we;
    memif_pkg::addr_t mem_addr;
    memif_pkg::word_t mem_wdata;
    memif_pkg::strb_t mem_wstrb;
    logic             mem_done;
    memif_pkg::word_t mem_rdata;

    memif_pkg::addr_t pc_q [$];             // expected fetch addresses
    int unsigned      cycle;
    int unsigned      req_cycle;            // cycle in which data_req is sampled
    int unsigned      ops_done;
    int unsigned      inst_count;
    int unsigned      op_state;             // 0 none, 1 requested, 2 on the bus
    logic             bus_open;
    logic             exp_we;
    memif_pkg::addr_t exp_addr;
    memif_pkg::word_t exp_wdata;
    memif_pkg::strb_t exp_wstrb;

    `include "tb_checks.svh"

    mem_access_top #(.RESET_PC(RESET_PC)) DUT (.*);

    always #20 aclk = ~aclk;

    function automatic memif_pkg::addr_t pick_window_addr();
        return WIN_BASE + (memif_pkg::addr_t'($urandom_range(WIN_WORDS - 1, 0)) << 2);
    endfunction

    task automatic quiet_check();
        check_bit("mem_req", mem_req, 1'b0);
        check_bit("inst_valid", inst_valid, 1'b0);
        check_bit("data_done", data_done, 1'b0);
        check_bit("data_busy", data_busy, 1'b0);
    endtask

    // memory side, one answer per mem_req after 1 to 4 cycles
    initial begin : responder
        int unsigned      lat;
        logic             we;
        memif_pkg::addr_t addr;
        memif_pkg::word_t wdata;
        memif_pkg::strb_t strb;
        mem_done  = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge aclk);
            if (rst_n === 1'b1 && mem_req === 1'b1) begin
                we    = mem_we;
                addr  = mem_addr;
                wdata = mem_wdata;
                strb  = mem_wstrb;
                lat   = $urandom_range(4, 1);
                repeat (lat - 1) @(posedge aclk);
                @(negedge aclk);
                if (we) begin
                    bus_mem[addr] = merge_word(bus_word(addr), wdata, strb);
                end else begin
                    mem_rdata = bus_word(addr);
                end
                mem_done = 1'b1;
                @(negedge aclk);
                mem_done = 1'b0;
            end
        end
    end

    always @(posedge aclk) begin : monitor
        memif_pkg::addr_t pc;
        if (rst_n === 1'b1) begin
            cycle++;
            if (cycle > MAX_CYCLES) begin
                stop_run($sformatf("timeout: run not finished after %0d cycles", MAX_CYCLES));
            end
            if (mem_req) begin
                if (bus_open) stop_run("a second mem_req appeared before the first mem_done");
                bus_open = 1'b1;
                if (op_state == 1 && cycle >= req_cycle + 2) begin    // data must win here
                    check_bus_addr(mem_addr, exp_addr);
                    check_bit("mem_we", mem_we, exp_we);
                    check_bus_word(mem_wdata, exp_wdata);
                    check_bus_strb(mem_wstrb, exp_wstrb);
                    op_state = 2;
                end else begin
                    check_bit("fetch mem_we", mem_we, 1'b0);
                    check_bus_strb(mem_wstrb, '0);
                end
            end
            if (mem_done) bus_open = 1'b0;
            if (inst_valid) begin                       // delivered before any same-cycle redirect
                pc = pc_q.pop_front();
                check_inst_pc(inst_pc, pc);
                check_inst_word(inst_word, ref_word(pc));
                pc_q.push_back(pc + memif_pkg::WORD_BYTES);
                inst_count++;
            end
            if (redirect) pc_q = {redirect_pc};
            if (data_done) begin
                if (op_state != 2) stop_run("data_done came without a data access on the bus");
                if (exp_we) begin
                    check_load_data(data_rdata, '0);   // store returns zero
                    ref_mem[exp_addr] = merge_word(ref_word(exp_addr), exp_wdata, exp_wstrb);
                end else begin
                    check_load_data(data_rdata, ref_word(exp_addr));
                end
                op_state = 0;
                ops_done++;
            end
        end
    end

    initial begin : stimulus
        void'($urandom(32'had22));
        rst_n       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        data_req    = 1'b0;
        data_we     = 1'b0;
        data_addr   = '0;
        data_wdata  = '0;
        data_wstrb  = '0;
        cycle       = 0;
        ops_done    = 0;
        inst_count  = 0;
        op_state    = 0;
        bus_open    = 1'b0;
        pc_q        = {RESET_PC};
        repeat (16) begin
            @(negedge aclk);
            quiet_check();
        end
        rst_n = 1'b1;
        @(negedge aclk);
        quiet_check();                              // first cycle out of reset
        while (ops_done < N_OPS) begin
            redirect = 1'b0;
            data_req = 1'b0;
            if ($urandom_range(15, 0) == 0) begin
                redirect    = 1'b1;
                redirect_pc = pick_window_addr();
            end
            if (op_state == 0 && !data_busy && $urandom_range(3, 0) == 0) begin
                data_req   = 1'b1;
                data_we    = 1'($urandom_range(1, 0));
                data_addr  = pick_window_addr();
                data_wdata = $urandom();
                data_wstrb = memif_pkg::strb_t'($urandom_range(15, 0));
                exp_we     = data_we;
                exp_addr   = data_addr;
                exp_wdata  = data_wdata;
                exp_wstrb  = data_wstrb;
                req_cycle  = cycle + 1;
                op_state   = 1;
            end
            @(negedge aclk);
        end
        if (inst_count == 0) begin
            stop_run("no instruction was delivered during the run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* logic/mem_access_top.sv */
/*
 * Memory access top level. Fetch unit and data port share one memory bus
 * through the arbiter; RESET_PC is passed down to the fetch unit.
 */
`timescale 1ns/1ns
`default_nettype none

module mem_access_top #(
    parameter memif_pkg::addr_t RESET_PC = 32'h0000_1000
) (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                redirect,
    input  memif_pkg::addr_t    redirect_pc,
    output logic                inst_valid,
    output memif_pkg::addr_t    inst_pc,
    output memif_pkg::word_t    inst_word,
    input  logic                data_req,
    input  logic                data_we,
    input  memif_pkg::addr_t    data_addr,
    input  memif_pkg::word_t    data_wdata,
    input  memif_pkg::strb_t    data_wstrb,
    output logic                data_done,
    output memif_pkg::word_t    data_rdata,
    output logic                data_busy,
    output logic                mem_req,
    output logic                mem_we,
    output memif_pkg::addr_t    mem_addr,
    output memif_pkg::word_t    mem_wdata,
    output memif_pkg::strb_t    mem_wstrb,
    input  logic                mem_done,
    input  memif_pkg::word_t    mem_rdata
);
    logic                fetch_pending;
    memif_pkg::addr_t    fetch_addr;
    logic                fetch_done;
    logic                data_pending;
    logic                op_we;
    memif_pkg::addr_t    op_addr;
    memif_pkg::word_t    op_wdata;
    memif_pkg::strb_t    op_wstrb;
    logic                data_done_int;
    memif_pkg::word_t    rdata_out;         // read word for whichever owner finished

    fetch_unit #(
        .RESET_PC       (RESET_PC)
    ) u_fetch_unit (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .fetch_done     (fetch_done),
        .fetch_rdata    (rdata_out),
        .fetch_pending  (fetch_pending),
        .fetch_addr     (fetch_addr),
        .inst_valid     (inst_valid),
        .inst_pc        (inst_pc),
        .inst_word      (inst_word)
    );

    data_port u_data_port (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .data_req       (data_req),
        .data_we        (data_we),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_wstrb     (data_wstrb),
        .grant_done     (data_done_int),
        .grant_rdata    (rdata_out),
        .data_pending   (data_pending),
        .op_we          (op_we),
        .op_addr        (op_addr),
        .op_wdata       (op_wdata),
        .op_wstrb       (op_wstrb),
        .data_busy      (data_busy),
        .data_done      (data_done),
        .data_rdata     (data_rdata)
    );

    bus_arbiter u_bus_arbiter (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .fetch_pending  (fetch_pending),
        .fetch_addr     (fetch_addr),
        .data_pending   (data_pending),
        .op_we          (op_we),
        .op_addr        (op_addr),
        .op_wdata       (op_wdata),
        .op_wstrb       (op_wstrb),
        .mem_done       (mem_done),
        .mem_rdata      (mem_rdata),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_wstrb      (mem_wstrb),
        .fetch_done     (fetch_done),
        .data_done_int  (data_done_int),
        .rdata_out      (rdata_out)
    );

endmodule

`default_nettype wire

/* logic/bus_arbiter.sv */
/*
 * Shares the single memory bus between fetch and data, data first.
 * Captures the winner's request, strobes mem_req once, waits for mem_done
 * and hands the completion and read word back to the owner.
 */
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                fetch_pending,
    input  memif_pkg::addr_t    fetch_addr,
    input  logic                data_pending,
    input  logic                op_we,
    input  memif_pkg::addr_t    op_addr,
    input  memif_pkg::word_t    op_wdata,
    input  memif_pkg::strb_t    op_wstrb,
    input  logic                mem_done,
    input  memif_pkg::word_t    mem_rdata,
    output logic                mem_req,
    output logic                mem_we,
    output memif_pkg::addr_t    mem_addr,
    output memif_pkg::word_t    mem_wdata,
    output memif_pkg::strb_t    mem_wstrb,
    output logic                fetch_done,
    output logic                data_done_int,
    output memif_pkg::word_t    rdata_out
);
    memif_pkg::arb_state_e state;
    memif_pkg::owner_e     owner;

    assign mem_req = (state == memif_pkg::ARB_ISSUE);  // one cycle per transaction

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state         <= memif_pkg::ARB_IDLE;
            owner         <= memif_pkg::OWN_FETCH;
            fetch_done    <= 1'b0;
            data_done_int <= 1'b0;
        end else begin
            fetch_done    <= 1'b0;
            data_done_int <= 1'b0;
            case (state)
                memif_pkg::ARB_IDLE: begin
                    if (data_pending) begin
                        owner <= memif_pkg::OWN_DATA;      // data wins a tie
                        state <= memif_pkg::ARB_ISSUE;
                    end else if (fetch_pending) begin
                        owner <= memif_pkg::OWN_FETCH;
                        state <= memif_pkg::ARB_ISSUE;
                    end
                end
                memif_pkg::ARB_ISSUE: begin
                    state <= memif_pkg::ARB_WAIT;
                end
                memif_pkg::ARB_WAIT: begin
                    if (mem_done) begin
                        fetch_done    <= (owner == memif_pkg::OWN_FETCH);
                        data_done_int <= (owner == memif_pkg::OWN_DATA);
                    end else if (fetch_done || data_done_int) begin
                        // owner has seen its strobe and dropped pending
                        state <= memif_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state <= memif_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    // bus fields of the winner, frozen once idle is left
    always_ff @(posedge aclk) begin
        if (state == memif_pkg::ARB_IDLE) begin
            if (data_pending) begin
                mem_we    <= op_we;
                mem_addr  <= op_addr;
                mem_wdata <= op_wdata;
                mem_wstrb <= op_wstrb;
            end else begin
                mem_we    <= 1'b0;              // fetch is a plain read
                mem_addr  <= fetch_addr;
                mem_wdata <= '0;
                mem_wstrb <= '0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (mem_done) begin
            rdata_out <= mem_rdata;
        end
    end

    // memory may only answer the one transaction in flight
    a_done_in_wait: assert property (
        @(posedge aclk) disable iff (!rst_n)
        mem_done |-> (state == memif_pkg::ARB_WAIT)
    ) else $error("mem_done outside the wait state");

    // a request on the bus always serves an owner that still waits for it
    a_req_owner_pending: assert property (
        @(posedge aclk) disable iff (!rst_n)
        mem_req |-> ((owner == memif_pkg::OWN_DATA) ? data_pending : fetch_pending)
    ) else $error("mem_req for an owner with nothing pending");

endmodule

`default_nettype wire

/* logic/data_port.sv */
/*
 * Holds one pending load or store from the data side until the arbiter
 * completes it, then strobes data_done with the load word.
 */
`timescale 1ns/1ns
`default_nettype none

module data_port (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                data_req,
    input  logic                data_we,
    input  memif_pkg::addr_t    data_addr,
    input  memif_pkg::word_t    data_wdata,
    input  memif_pkg::strb_t    data_wstrb,
    input  logic                grant_done,
    input  memif_pkg::word_t    grant_rdata,
    output logic                data_pending,
    output logic                op_we,
    output memif_pkg::addr_t    op_addr,
    output memif_pkg::word_t    op_wdata,
    output memif_pkg::strb_t    op_wstrb,
    output logic                data_busy,
    output logic                data_done,
    output memif_pkg::word_t    data_rdata
);
    // busy for exactly as long as the request waits on the bus
    assign data_busy = data_pending;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            data_pending <= 1'b0;
            data_done    <= 1'b0;
        end else begin
            data_done <= grant_done;
            if (data_req) begin
                data_pending <= 1'b1;
            end else if (grant_done) begin
                data_pending <= 1'b0;           // falls together with data_done
            end
        end
    end

    // request fields, held stable while pending
    always_ff @(posedge aclk) begin
        if (data_req) begin
            op_we    <= data_we;
            op_addr  <= data_addr;
            op_wdata <= data_wdata;
            op_wstrb <= data_wstrb;
        end
    end

    always_ff @(posedge aclk) begin
        if (grant_done) begin
            data_rdata <= op_we ? '0 : grant_rdata;    // stores return zero
        end
    end

    // the source must wait for the previous access to finish
    a_req_not_busy: assert property (
        @(posedge aclk) disable iff (!rst_n)
        data_req |-> !data_busy
    ) else $error("data_req while data_busy");

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
/*
 * Sequential instruction fetch from RESET_PC with redirect support.
 * One fetch is outstanding at a time; words fetched before a redirect are dropped.
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter memif_pkg::addr_t RESET_PC = 32'h0000_1000
) (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                redirect,
    input  memif_pkg::addr_t    redirect_pc,
    input  logic                fetch_done,
    input  memif_pkg::word_t    fetch_rdata,
    output logic                fetch_pending,
    output memif_pkg::addr_t    fetch_addr,
    output logic                inst_valid,
    output memif_pkg::addr_t    inst_pc,
    output memif_pkg::word_t    inst_word
);
    logic stale;        // outstanding fetch belongs to an old address
    logic relaunch;     // start a fetch next cycle without delivering
    logic deliver;

    assign deliver = fetch_done && !stale && !redirect;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            fetch_addr    <= RESET_PC;
            fetch_pending <= 1'b0;
            stale         <= 1'b0;
            relaunch      <= 1'b1;              // first fetch right after reset
            inst_valid    <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            relaunch   <= 1'b0;
            if (relaunch || inst_valid) begin
                fetch_pending <= 1'b1;          // next word, one cycle after delivery
            end
            if (fetch_done) begin
                fetch_pending <= 1'b0;
                if (deliver) begin
                    inst_valid <= 1'b1;
                    fetch_addr <= fetch_addr + memif_pkg::addr_t'(memif_pkg::WORD_BYTES);
                end else begin
                    stale    <= 1'b0;           // drop it and refetch at new pc
                    relaunch <= 1'b1;
                end
            end
            if (redirect) begin
                fetch_addr <= redirect_pc;
                if (fetch_pending && !fetch_done) begin
                    stale <= 1'b1;              // still in flight, discard on return
                end
            end
        end
    end

    // word and its address, valid with inst_valid
    always_ff @(posedge aclk) begin
        if (deliver) begin
            inst_pc   <= fetch_addr;
            inst_word <= fetch_rdata;
        end
    end

    // a completion from the arbiter must match a fetch we asked for
    a_done_has_fetch: assert property (
        @(posedge aclk) disable iff (!rst_n)
        fetch_done |-> fetch_pending
    ) else $error("fetch completion without an outstanding fetch");

endmodule

`default_nettype wire

/* logic/memif_pkg.sv */
/*
 * Shared types for the memory access block: bus widths, bus owner and the
 * arbiter state encoding. Referenced by scoped name, never imported.
 */
`default_nettype none

package memif_pkg;

    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned WORD_W     = 32;
    localparam int unsigned WORD_BYTES = WORD_W / 8;    // fetch address step

    typedef logic [ADDR_W-1:0]     addr_t;              // byte address on the bus
    typedef logic [WORD_W-1:0]     word_t;              // instruction or data word
    typedef logic [WORD_BYTES-1:0] strb_t;              // one write enable per byte

    // who holds the memory bus
    typedef enum logic {
        OWN_FETCH = 1'b0,
        OWN_DATA  = 1'b1
    } owner_e;

    // arbiter FSM, one transaction at a time
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_ISSUE = 2'd1,
        ARB_WAIT  = 2'd2
    } arb_state_e;

endpackage

`default_nettype wire
